//--- all.f
+incdir+source
+incdir+verification
source/dataMemPkg.sv
source/dataCache.sv
source/mainMemory.sv
source/storeMerger.sv
source/loadAligner.sv
source/dataMemoryController.sv
verification/dataMemoryTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = dataMemoryTb
FILELIST  = all.f
OBJDIR    = obj_dir
PASS_MSG  = Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

//--- verification/tbRefModel.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic [`DATA_WIDTH-1:0] shadowMem [`MEM_WORDS];
logic [25:0]            shadowTag [`CACHE_LINES];
logic                   shadowValid [`CACHE_LINES];

// load result from a stored word, by extraction and extension rules
function automatic logic [`DATA_WIDTH-1:0] expectedLoad(input memOp_t kind,
        input logic [1:0] offset, input logic [`DATA_WIDTH-1:0] word);
    logic [`DATA_WIDTH-1:0] shifted;
    logic [7:0]             b;
    logic [15:0]            h;
    shifted = word >> (8 * offset);
    b = shifted[7:0];
    h = 16'(word >> (16 * offset[1]));   // bit 0 plays no part
    case (kind)
        LOAD_BYTE:  return 32'($signed(b));
        LOAD_HALF:  return 32'($signed(h));
        ULOAD_BYTE: return 32'(b);
        ULOAD_HALF: return 32'(h);
        default:    return word;
    endcase
endfunction

function automatic logic [`DATA_WIDTH-1:0] mergedStoreWord(input memOp_t kind,
        input logic [1:0] offset, input logic [`DATA_WIDTH-1:0] oldWord,
        input logic [`DATA_WIDTH-1:0] data);
    logic [`DATA_WIDTH-1:0] mask;
    int                     shift;
    case (kind)
        STORE_BYTE: begin
            shift = 8 * offset;
            mask  = 32'h0000_00FF << shift;
        end
        STORE_HALF: begin
            shift = 16 * offset[1];
            mask  = 32'h0000_FFFF << shift;
        end
        default: begin
            shift = 0;
            mask  = '1;
        end
    endcase
    return (oldWord & ~mask) | ((data << shift) & mask);
endfunction

function automatic logic cacheHolds(input logic [`DATA_WIDTH-1:0] a);
    return shadowValid[a[5:2]] && (shadowTag[a[5:2]] == a[31:6]);
endfunction

function automatic void fillShadowLine(input logic [`DATA_WIDTH-1:0] a);
    shadowValid[a[5:2]] = 1'b1;
    shadowTag[a[5:2]]   = a[31:6];
endfunction

function automatic void clearShadow();
    for (int i = 0; i < `MEM_WORDS; i++) begin
        shadowMem[i] = '0;
    end
    for (int i = 0; i < `CACHE_LINES; i++) begin
        shadowValid[i] = 1'b0;
        shadowTag[i]   = '0;
    end
endfunction

`endif

//--- verification/dataMemoryTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "dataMem_cfg.svh"

module dataMemoryTb import dataMemPkg::*; ();

    localparam int ClkPeriod   = 40;
    localparam int ResetCycles = 8;
    localparam int WordTests   = 4;
    localparam int MergeTests  = 8;
    localparam int RandomOps   = 300;
    localparam int NumRequests = 2 + WordTests * 18 + MergeTests * 3 + 10 + 6 + RandomOps;
    localparam int WatchdogNs  =
        (NumRequests * (`MEM_LATENCY + 4) + ResetCycles + 20) * ClkPeriod;

    logic                   clk;
    logic                   rstN;
    logic                   reqValid;
    memOp_t                 op;
    logic [`DATA_WIDTH-1:0] addr;
    logic [`DATA_WIDTH-1:0] wrData;
    logic                   respValid;
    logic                   hit;
    logic                   busy;
    logic [`DATA_WIDTH-1:0] rdData;

    int                     cycleCount = 0;
    int                     sentCycle;
    logic [`DATA_WIDTH-1:0] wantDataQ [$];
    bit                     wantHitQ [$];
    int                     wantLatQ [$];
    string                  descQ [$];

    string                  respWhat;
    int                     respLatency;
    int                     respWantLat;
    bit                     respWantHit;
    logic [`DATA_WIDTH-1:0] respWantData;

    `include "tbRefModel.svh"

    dataMemoryController dataMemoryController_inst (
        .clk       (clk),
        .rstN      (rstN),
        .reqValid  (reqValid),
        .op        (op),
        .addr      (addr),
        .wrData    (wrData),
        .respValid (respValid),
        .hit       (hit),
        .busy      (busy),
        .rdData    (rdData)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic checkValue(input logic [`DATA_WIDTH-1:0] actual,
            input logic [`DATA_WIDTH-1:0] expected, input string what);
        if (actual !== expected) begin
            stopWithFailure($sformatf("Mismatch at %0d ns: %s, got %h, expected %h",
                $time, what, actual, expected));
        end
    endtask

    // expectation is queued before the request goes out
    task automatic issueRequest(input memOp_t kind, input logic [`DATA_WIDTH-1:0] where,
            input logic [`DATA_WIDTH-1:0] data);
        logic                   load;
        logic                   wantHit;
        logic [`DATA_WIDTH-1:0] wantWord;
        logic [7:0]             wIdx;
        string                  desc;
        load    = !(kind inside {STORE_BYTE, STORE_HALF, STORE_WORD});
        wantHit = cacheHolds(where);
        wIdx    = where[9:2];
        if (load) begin
            wantWord = expectedLoad(kind, where[1:0], shadowMem[wIdx]);
            if (!wantHit) begin
                fillShadowLine(where);      // miss fills the line
            end
        end else begin
            shadowMem[wIdx] = mergedStoreWord(kind, where[1:0], shadowMem[wIdx], data);
            wantWord = shadowMem[wIdx];
        end
        desc = $sformatf("%s at %h", kind.name(), where);
        wantDataQ.push_back(wantWord);
        wantHitQ.push_back(wantHit);
        wantLatQ.push_back((load && wantHit) ? 1 : (`MEM_LATENCY + 1));
        descQ.push_back(desc);
        @(posedge clk);
        sentCycle = cycleCount;
        reqValid <= 1'b1;
        op       <= kind;
        addr     <= where;
        wrData   <= data;
        @(posedge clk);
        reqValid <= 1'b0;
        do begin
            @(negedge clk);
            if (!respValid) begin
                checkValue(32'(busy), 32'd1, {desc, " busy while waiting"});
            end
        end while (!respValid);
    endtask

    // responses are checked in the middle of the cycle
    always @(negedge clk) begin
        if (rstN && respValid) begin
            if (descQ.size() == 0) begin
                stopWithFailure("Response strobe arrived with no request outstanding");
            end else begin
                respWhat     = descQ.pop_front();
                respWantLat  = wantLatQ.pop_front();
                respWantHit  = wantHitQ.pop_front();
                respWantData = wantDataQ.pop_front();
                respLatency  = cycleCount - sentCycle - 1;
                checkValue(32'(respLatency), 32'(respWantLat), {respWhat, " latency"});
                checkValue(32'(hit), 32'(respWantHit), {respWhat, " hit flag"});
                checkValue(rdData, respWantData, {respWhat, " data"});
            end
        end
    end

    task automatic powerOnLoads();
        logic [`DATA_WIDTH-1:0] a;
        a = {22'd0, 8'($urandom_range(0, 255)), 2'b00};
        issueRequest(LOAD_WORD, a, '0);     // zero, miss
        issueRequest(LOAD_WORD, a, '0);     // zero, hit
    endtask

    task automatic wordStoreLoadSweep();
        logic [`DATA_WIDTH-1:0] a;
        logic [`DATA_WIDTH-1:0] d;
        for (int i = 0; i < WordTests; i++) begin
            a = {22'd0, 8'($urandom_range(0, 255)), 2'b00};
            d = (i == 0) ? 32'h807F_FF01 : (i == 1) ? 32'h7FFF_0080 : $urandom();
            issueRequest(STORE_WORD, a, d);
            issueRequest(LOAD_WORD, a, '0);
            for (int k = 0; k < 4; k++) begin
                issueRequest(LOAD_BYTE, a + 32'(k), '0);
                issueRequest(ULOAD_BYTE, a + 32'(k), '0);
                issueRequest(LOAD_HALF, a + 32'(k), '0);
                issueRequest(ULOAD_HALF, a + 32'(k), '0);
            end
        end
    endtask

    task automatic partialStores();
        logic [`DATA_WIDTH-1:0] a;
        memOp_t                 kind;
        for (int i = 0; i < MergeTests; i++) begin
            a    = {22'd0, 8'($urandom_range(0, 255)), 2'($urandom_range(0, 3))};
            kind = (i % 2 == 0) ? STORE_BYTE : STORE_HALF;
            issueRequest(STORE_WORD, {a[31:2], 2'b00}, $urandom());
            issueRequest(kind, a, $urandom());
            issueRequest(LOAD_WORD, {a[31:2], 2'b00}, '0);
        end
    endtask

    task automatic evictionSequence();
        logic [3:0]             idx;
        logic [3:0]             tagA;
        logic [`DATA_WIDTH-1:0] addrA;
        logic [`DATA_WIDTH-1:0] addrB;
        for (int i = 0; i < 2; i++) begin
            idx   = 4'($urandom_range(0, 15));
            tagA  = 4'($urandom_range(0, 15));
            addrA = {22'd0, tagA, idx, 2'b00};
            addrB = {22'd0, tagA ^ 4'h5, idx, 2'b00};   // same line, other tag
            issueRequest(LOAD_WORD, addrA, '0);
            issueRequest(LOAD_WORD, addrA, '0);
            issueRequest(LOAD_WORD, addrB, '0);
            issueRequest(LOAD_WORD, addrA, '0);
            issueRequest(LOAD_WORD, addrB, '0);
        end
    endtask

    task automatic coherenceAfterStore();
        logic [`DATA_WIDTH-1:0] a;
        for (int i = 0; i < 2; i++) begin
            a = {22'd0, 8'($urandom_range(0, 255)), 2'b00};
            issueRequest(LOAD_WORD, a, '0);
            if (i == 0) begin
                issueRequest(STORE_WORD, a, $urandom());
            end else begin
                issueRequest(STORE_HALF, a + 32'd2, $urandom());
            end
            issueRequest(LOAD_WORD, a, '0);
        end
    endtask

    task automatic randomMix();
        logic [`DATA_WIDTH-1:0] a;
        memOp_t                 kind;
        for (int i = 0; i < RandomOps; i++) begin
            kind = memOp_t'(3'($urandom_range(0, 7)));
            a    = {24'd0, 6'($urandom_range(0, 47)), 2'($urandom_range(0, 3))};
            issueRequest(kind, a, $urandom());
        end
    endtask

    initial begin
        #(WatchdogNs);
        stopWithFailure($sformatf("Timeout: no response from the DUT within %0d ns",
            WatchdogNs));
    end

    initial begin
        void'($urandom(54986));
        clearShadow();
        rstN     = 1'b0;
        reqValid = 1'b0;
        op       = LOAD_WORD;
        addr     = '0;
        wrData   = '0;
        repeat (ResetCycles) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkValue(32'(busy), 32'd0, "busy after reset");
        checkValue(32'(respValid), 32'd0, "respValid after reset");
        powerOnLoads();
        wordStoreLoadSweep();
        partialStores();
        evictionSequence();
        coherenceAfterStore();
        randomMix();
        repeat (2) @(negedge clk);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/dataMemoryController.sv
`timescale 1ns/1ps
`default_nettype none
`include "dataMem_cfg.svh"

module dataMemoryController import dataMemPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   reqValid,
    input  memOp_t                 op,
    input  logic [`DATA_WIDTH-1:0] addr,
    input  logic [`DATA_WIDTH-1:0] wrData,
    output logic                   respValid,
    output logic                   hit,
    output logic                   busy,
    output logic [`DATA_WIDTH-1:0] rdData
);

    localparam int WordBits = $clog2(`MEM_WORDS);

    localparam logic [1:0] Idle       = 2'd0;
    localparam logic [1:0] LoadMiss   = 2'd1;
    localparam logic [1:0] StoreRead  = 2'd2;
    localparam logic [1:0] StoreWrite = 2'd3;

    logic [1:0]             state;
    memAddr_u               reqAddr;
    memOp_t                 reqOp;
    logic [`DATA_WIDTH-1:0] reqData;
    logic                   hitQ;
    logic                   storeRespQ;

    memAddr_u               curAddr;
    memOp_t                 curOp;
    logic                   accept;
    logic                   isStoreOp;
    logic                   storeResp;

    logic                   cacheHit;
    logic [`DATA_WIDTH-1:0] cacheData;
    logic                   fillStrobe;
    logic                   updStrobe;
    logic [`DATA_WIDTH-1:0] lineData;
    logic                   memRdStrobe;
    logic                   memWrStrobe;
    logic                   memRdValid;
    logic [`DATA_WIDTH-1:0] memRdData;
    logic                   mergeStrobe;
    logic                   mergeValid;
    logic [`DATA_WIDTH-1:0] mergedWord;
    logic                   alignStrobe;
    logic                   alignValid;
    logic [`DATA_WIDTH-1:0] alignWord;
    logic [`DATA_WIDTH-1:0] loadData;

    assign busy   = (state != Idle);
    assign accept = reqValid && !busy;    // ignored while busy

    // live request when idle, latched one otherwise
    assign curAddr   = busy ? reqAddr : memAddr_u'(addr);
    assign curOp     = busy ? reqOp : op;
    assign isStoreOp = op inside {STORE_BYTE, STORE_HALF, STORE_WORD};

    assign memRdStrobe = accept && (isStoreOp || !cacheHit);
    assign fillStrobe  = (state == LoadMiss) && memRdValid;
    assign alignStrobe = (accept && !isStoreOp && cacheHit) || fillStrobe;
    assign alignWord   = busy ? memRdData : cacheData;
    assign mergeStrobe = (state == StoreRead) && memRdValid;
    assign memWrStrobe = (state == StoreWrite) && mergeValid;
    assign updStrobe   = memWrStrobe;     // write-through update
    assign lineData    = fillStrobe ? memRdData : mergedWord;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= Idle;
            hitQ       <= 1'b0;
            storeRespQ <= 1'b0;
        end else begin
            storeRespQ <= storeResp;
            if (accept) begin
                hitQ <= cacheHit;         // cache is untouched until the response
            end
            case (state)
                Idle: begin
                    if (accept && isStoreOp) begin
                        state <= StoreRead;
                    end else if (accept && !cacheHit) begin
                        state <= LoadMiss;
                    end
                end
                LoadMiss:   if (memRdValid) state <= Idle;
                StoreRead:  if (memRdValid) state <= StoreWrite;
                StoreWrite: if (mergeValid) state <= Idle;
                default:    state <= Idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            reqAddr <= memAddr_u'(addr);
            reqOp   <= op;
            reqData <= wrData;
        end
    end

    // stores answer with the merged word, loads with the aligned one
    assign storeResp = mergeValid || (storeRespQ && !alignValid);
    assign respValid = alignValid || mergeValid;
    assign rdData    = storeResp ? mergedWord : loadData;
    assign hit       = hitQ;

    dataCache dataCache_inst (
        .clk        (clk),
        .rstN       (rstN),
        .lookupAddr (curAddr),
        .fillStrobe (fillStrobe),
        .updStrobe  (updStrobe),
        .lineData   (lineData),
        .cacheHit   (cacheHit),
        .cacheData  (cacheData)
    );

    mainMemory mainMemory_inst (
        .clk         (clk),
        .rstN        (rstN),
        .memRdStrobe (memRdStrobe),
        .memWrStrobe (memWrStrobe),
        .wordAddr    (curAddr.raw[WordBits+1:2]),   // wraps above 1 KB
        .memWrData   (mergedWord),
        .memRdValid  (memRdValid),
        .memRdData   (memRdData)
    );

    storeMerger storeMerger_inst (
        .clk         (clk),
        .rstN        (rstN),
        .mergeStrobe (mergeStrobe),
        .op          (reqOp),
        .offset      (reqAddr.fields.offset),
        .oldWord     (memRdData),
        .storeData   (reqData),
        .mergeValid  (mergeValid),
        .mergedWord  (mergedWord)
    );

    loadAligner loadAligner_inst (
        .clk         (clk),
        .rstN        (rstN),
        .alignStrobe (alignStrobe),
        .op          (curOp),
        .offset      (curAddr.fields.offset),
        .word        (alignWord),
        .alignValid  (alignValid),
        .loadData    (loadData)
    );

endmodule

`default_nettype wire

//--- source/loadAligner.sv
`timescale 1ns/1ps
`default_nettype none
`include "dataMem_cfg.svh"

module loadAligner import dataMemPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   alignStrobe,
    input  memOp_t                 op,
    input  logic [1:0]             offset,
    input  logic [`DATA_WIDTH-1:0] word,
    output logic                   alignValid,
    output logic [`DATA_WIDTH-1:0] loadData
);

    logic [7:0]             selByte;
    logic [15:0]            selHalf;
    logic [`DATA_WIDTH-1:0] alignNext;

    assign selByte = word[{offset, 3'b000} +: 8];
    assign selHalf = offset[1] ? word[31:16] : word[15:0];   // bit 0 ignored

    always_comb begin
        case (op)
            LOAD_BYTE:  alignNext = {{24{selByte[7]}}, selByte};
            LOAD_HALF:  alignNext = {{16{selHalf[15]}}, selHalf};
            ULOAD_BYTE: alignNext = {24'b0, selByte};
            ULOAD_HALF: alignNext = {16'b0, selHalf};
            LOAD_WORD:  alignNext = word;
            default:    alignNext = word;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            alignValid <= 1'b0;
        end else begin
            alignValid <= alignStrobe;
        end
    end

    always_ff @(posedge clk) begin
        if (alignStrobe) begin
            loadData <= alignNext;
        end
    end

endmodule

`default_nettype wire

//--- source/storeMerger.sv
`timescale 1ns/1ps
`default_nettype none
`include "dataMem_cfg.svh"

module storeMerger import dataMemPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   mergeStrobe,
    input  memOp_t                 op,
    input  logic [1:0]             offset,
    input  logic [`DATA_WIDTH-1:0] oldWord,
    input  logic [`DATA_WIDTH-1:0] storeData,
    output logic                   mergeValid,
    output logic [`DATA_WIDTH-1:0] mergedWord
);

    logic [`DATA_WIDTH-1:0] mergeNext;

    always_comb begin
        mergeNext = oldWord;
        case (op)
            STORE_BYTE: mergeNext[{offset, 3'b000} +: 8] = storeData[7:0];
            STORE_HALF: mergeNext[{offset[1], 4'b0000} +: 16] = storeData[15:0];
            STORE_WORD: mergeNext = storeData;
            default:    mergeNext = oldWord;   // loads leave the word alone
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mergeValid <= 1'b0;
        end else begin
            mergeValid <= mergeStrobe;
        end
    end

    always_ff @(posedge clk) begin
        if (mergeStrobe) begin
            mergedWord <= mergeNext;     // held until the next merge
        end
    end

endmodule

`default_nettype wire

//--- source/mainMemory.sv
`timescale 1ns/1ps
`default_nettype none
`include "dataMem_cfg.svh"

module mainMemory import dataMemPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   memRdStrobe,
    input  logic                   memWrStrobe,
    input  logic [7:0]             wordAddr,
    input  logic [`DATA_WIDTH-1:0] memWrData,
    output logic                   memRdValid,
    output logic [`DATA_WIDTH-1:0] memRdData
);

    logic [`DATA_WIDTH-1:0] ram [`MEM_WORDS];

    logic [`MEM_LATENCY-1:0] validPipe;
    logic [`DATA_WIDTH-1:0]  dataPipe [`MEM_LATENCY];

    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) begin
            ram[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (memWrStrobe) begin
            ram[wordAddr] <= memWrData;  // single-cycle write
        end
    end

    // valid bits of the read pipeline
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validPipe <= '0;
        end else begin
            validPipe[0] <= memRdStrobe;
            for (int i = 1; i < `MEM_LATENCY; i++) begin
                validPipe[i] <= validPipe[i-1];
            end
        end
    end

    // data travels alongside its valid bit
    always_ff @(posedge clk) begin
        dataPipe[0] <= ram[wordAddr];
        for (int i = 1; i < `MEM_LATENCY; i++) begin
            dataPipe[i] <= dataPipe[i-1];
        end
    end

    assign memRdValid = validPipe[`MEM_LATENCY-1];
    assign memRdData  = dataPipe[`MEM_LATENCY-1];

endmodule

`default_nettype wire

//--- source/dataCache.sv
`timescale 1ns/1ps
`default_nettype none
`include "dataMem_cfg.svh"

module dataCache import dataMemPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  memAddr_u               lookupAddr,
    input  logic                   fillStrobe,
    input  logic                   updStrobe,
    input  logic [`DATA_WIDTH-1:0] lineData,
    output logic                   cacheHit,
    output logic [`DATA_WIDTH-1:0] cacheData
);

    logic [25:0]            tagArr [`CACHE_LINES];
    logic [`DATA_WIDTH-1:0] dataArr [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] validArr;

    logic [3:0]  lineIdx;
    logic [25:0] lineTag;
    logic        tagMatch;

    assign lineIdx = lookupAddr.fields.index;
    assign lineTag = lookupAddr.fields.tag;

    // hit check is purely combinational
    assign tagMatch  = (tagArr[lineIdx] == lineTag);
    assign cacheHit  = validArr[lineIdx] && tagMatch;
    assign cacheData = dataArr[lineIdx];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validArr <= '0;              // all lines empty
        end else if (fillStrobe) begin
            validArr[lineIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fillStrobe) begin
            tagArr[lineIdx] <= lineTag;
        end
    end

    // a fill always writes, an update only on a hit
    always_ff @(posedge clk) begin
        if (fillStrobe) begin
            dataArr[lineIdx] <= lineData;
        end else if (updStrobe && cacheHit) begin
            dataArr[lineIdx] <= lineData; // write-through keeps line current
        end
    end

endmodule

`default_nettype wire

//--- source/dataMemPkg.sv
`default_nettype none
`include "dataMem_cfg.svh"

package dataMemPkg;

    typedef enum logic [2:0] {
        LOAD_BYTE  = 3'd0,
        LOAD_HALF  = 3'd1,
        LOAD_WORD  = 3'd2,
        ULOAD_BYTE = 3'd3,
        ULOAD_HALF = 3'd4,
        STORE_BYTE = 3'd5,
        STORE_HALF = 3'd6,
        STORE_WORD = 3'd7
    } memOp_t;

    // same address word, seen whole or split for the cache
    typedef union packed {
        logic [`DATA_WIDTH-1:0] raw;
        struct packed {
            logic [25:0] tag;
            logic [3:0]  index;    // selects one of the lines
            logic [1:0]  offset;   // byte within the word
        } fields;
    } memAddr_u;

endpackage

`default_nettype wire

//--- source/dataMem_cfg.svh
`ifndef DATAMEM_CFG_SVH
`define DATAMEM_CFG_SVH

// word size of the load/store path
`define DATA_WIDTH 32

`define MEM_WORDS 256    // main memory depth in words

// cycles from read strobe to read data
`define MEM_LATENCY 3

`define CACHE_LINES 16   // one word per line

`endif
